/* verilog/mix_pkg.sv */
// widths, fixed-point format and frame type shared by the stereo mixer
// gains are unsigned with Q_BITS fraction bits, so 256 means unity
// credit counters must hold 0..FIFO_DEPTH inclusive
package mix_pkg;

  // ------------------------------------------------------------
  // sample and gain format
  // ------------------------------------------------------------
  localparam int AUDIO_W = 24;                  // signed two's complement
  localparam int GAIN_W  = 12;                  // unsigned gain word
  localparam int Q_BITS  = 8;                   // fraction bits of a gain
  localparam int ACC_W   = AUDIO_W + GAIN_W + 4; // product plus sum headroom

  // ------------------------------------------------------------
  // mixer shape and buffering
  // ------------------------------------------------------------
  localparam int NR_CH      = 2;                  // ch0 = adc left, ch1 = adc right
  localparam int FIFO_DEPTH = 4;                  // frame slots in the buffer
  localparam int ENG_SLOTS  = 2;                  // frames the engine may hold
  localparam int CRED_W     = 3;                  // credit / fill counters
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH); // buffer pointer width
  localparam int ENG_PTR_W  = $clog2(ENG_SLOTS);  // output queue pointer width

  // ------------------------------------------------------------
  // types
  // ------------------------------------------------------------
  typedef logic signed [AUDIO_W-1:0] sample_t;
  typedef logic [GAIN_W-1:0]         gain_t;

  // left in the upper half, right in the lower half
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_frame_t;

  // saturation limits
  localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(AUDIO_W-1){1'b1}}});
  localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(AUDIO_W-1){1'b0}}});

endpackage

/* verilog/frame_assembler.sv */
`timescale 1ns/1ps
// pairs adc samples into stereo frames: adc_last low = left, high = right
// a right sample with no left before it reuses the stored left, zero after reset
// adc_ready follows the credit count only, left samples are also held off at zero
module frame_assembler
  import mix_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  // adc stream
  input  sample_t       adc_data,
  input  logic          adc_valid,
  input  logic          adc_last,
  output logic          adc_ready,
  // statistics
  input  logic          clear_stats,
  output sample_t       min_amp,
  output sample_t       max_amp,
  // link to the frame buffer
  output logic          asm_valid,
  output stereo_frame_t asm_frame,
  input  logic          asm_credit
);

  logic [CRED_W-1:0] cred_cnt;   // free slots the buffer has granted
  sample_t           left_q;     // last accepted left sample
  logic              adc_fire;   // sample handshake
  logic              left_fire;
  logic              right_fire; // completes a frame, spends a credit

  assign adc_ready  = (cred_cnt != '0);
  assign adc_fire   = adc_valid && adc_ready;
  assign left_fire  = adc_fire && !adc_last;
  assign right_fire = adc_fire && adc_last;

  // ------------------------------------------------------------
  // credits and frame strobe
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cred_cnt  <= CRED_W'(FIFO_DEPTH); // buffer starts empty
      asm_valid <= 1'b0;
      left_q    <= '0;
    end else begin
      cred_cnt  <= cred_cnt - CRED_W'(right_fire) + CRED_W'(asm_credit);
      asm_valid <= right_fire;          // frame leaves the cycle after the right sample
      if (left_fire) begin
        left_q <= adc_data;
      end
    end
  end

  // frame payload
  always_ff @(posedge clk) begin
    if (right_fire) begin
      asm_frame.left  <= left_q;
      asm_frame.right <= adc_data;
    end
  end

  // ------------------------------------------------------------
  // amplitude statistics
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      min_amp <= '0;
      max_amp <= '0;
    end else if (clear_stats) begin  // clear beats a same-cycle sample
      min_amp <= '0;
      max_amp <= '0;
    end else if (adc_fire) begin
      if (adc_data < min_amp) begin  // signed compare
        min_amp <= adc_data;
      end
      if (adc_data > max_amp) begin
        max_amp <= adc_data;
      end
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // the buffer never returns more credits than were spent
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    cred_cnt <= CRED_W'(FIFO_DEPTH));

endmodule

/* verilog/frame_fifo.sv */
`timescale 1ns/1ps
// credit-fed frame queue between producer and mix engine, no ready signals
// pops the head whenever it holds a frame and an engine credit
// fifo_valid and fifo_frame are combinational from the queue state
module frame_fifo
  import mix_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  // from the producer
  input  logic          asm_valid,
  input  stereo_frame_t asm_frame,
  output logic          asm_credit,
  // to the engine
  output logic          fifo_valid,
  output stereo_frame_t fifo_frame,
  input  logic          eng_credit
);

  stereo_frame_t         mem [FIFO_DEPTH]; // frame slots
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [CRED_W-1:0]     count;            // frames stored
  logic [CRED_W-1:0]     eng_cred;         // engine slots still free
  logic                  pop;

  assign pop        = (count != '0) && (eng_cred != '0);
  assign fifo_valid = pop;                 // one pulse per frame handed over
  assign fifo_frame = mem[rd_ptr];

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (asm_valid) begin
      mem[wr_ptr] <= asm_frame;
    end
  end

  // ------------------------------------------------------------
  // pointers, fill level and credits
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      eng_cred   <= CRED_W'(ENG_SLOTS); // engine starts empty
      asm_credit <= 1'b0;
    end else begin
      if (asm_valid) begin
        wr_ptr <= wr_ptr + 1'b1;       // wraps, depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count      <= count + CRED_W'(asm_valid) - CRED_W'(pop);
      eng_cred   <= eng_cred - CRED_W'(pop) + CRED_W'(eng_credit);
      asm_credit <= pop;               // slot freed, hand it back a cycle later
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // producer credits keep it from writing into a full queue
  a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
    asm_valid |-> (count != CRED_W'(FIFO_DEPTH)));

  // engine never returns a credit it was not given
  a_eng_cred_bound: assert property (@(posedge clk) disable iff (!rst_n)
    eng_cred <= CRED_W'(ENG_SLOTS));

endmodule

/* verilog/mix_engine.sv */
`timescale 1ns/1ps
// gain, pan, sum and saturate pipeline with a 2-slot queue and dac serialiser
// gains, pan and out_gain are captured as a frame enters, change them while idle
// left sample reaches dac_valid 3 cycles after fifo_valid when the serialiser is free
module mix_engine
  import mix_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  // frame link
  input  logic             fifo_valid,
  input  stereo_frame_t    fifo_frame,
  output logic             eng_credit,
  // configuration
  input  gain_t            chan_gain_0,
  input  gain_t            chan_gain_1,
  input  gain_t            out_gain,
  input  logic [NR_CH-1:0] chan_pan,     // 0 = left bus, 1 = right bus
  input  logic             clear_stats,
  output logic [NR_CH-1:0] chan_clip,    // sticky
  output logic             out_clip,     // sticky
  // dac stream
  output sample_t          dac_data,
  output logic             dac_valid,
  output logic             dac_last,
  input  logic             dac_ready
);

  typedef enum logic [1:0] {S_IDLE, S_LEFT, S_RIGHT} ser_state_t;

  // floor shift by Q_BITS then clamp, msb of the result flags a clip
  function automatic logic [AUDIO_W:0] scale_sat(input logic signed [ACC_W-1:0] prod);
    logic signed [ACC_W-1:0] shifted;
    shifted = prod >>> Q_BITS;
    if (shifted > SAMPLE_MAX) begin
      return {1'b1, SAMPLE_MAX};
    end else if (shifted < SAMPLE_MIN) begin
      return {1'b1, SAMPLE_MIN};
    end
    return {1'b0, shifted[AUDIO_W-1:0]};
  endfunction

  // ------------------------------------------------------------
  // stage 1: per-channel gain
  // ------------------------------------------------------------
  sample_t                 ch_in   [NR_CH];
  gain_t                   ch_gain [NR_CH];
  logic signed [ACC_W-1:0] ch_prod [NR_CH];
  logic [AUDIO_W:0]        ch_sat  [NR_CH]; // {clip, sample}
  sample_t                 s1_ch   [NR_CH];
  logic                    s1_valid;
  logic [NR_CH-1:0]        s1_pan;
  gain_t                   s1_gain;         // out_gain rides along with the frame

  assign ch_in[0]   = fifo_frame.left;
  assign ch_in[1]   = fifo_frame.right;
  assign ch_gain[0] = chan_gain_0;
  assign ch_gain[1] = chan_gain_1;

  always_comb begin
    for (int i = 0; i < NR_CH; i++) begin
      ch_prod[i] = ch_in[i] * $signed({1'b0, ch_gain[i]}); // gain is unsigned
      ch_sat[i]  = scale_sat(ch_prod[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_valid) begin
      for (int i = 0; i < NR_CH; i++) begin
        s1_ch[i] <= ch_sat[i][AUDIO_W-1:0];
      end
      s1_pan  <= chan_pan;
      s1_gain <= out_gain;
    end
  end

  // ------------------------------------------------------------
  // stage 2: pan and sum, stage 3: output gain
  // ------------------------------------------------------------
  logic signed [ACC_W-1:0] mix_sum  [2]; // 0 left bus, 1 right bus
  logic signed [ACC_W-1:0] s2_sum   [2];
  logic                    s2_valid;
  gain_t                   s2_gain;
  logic signed [ACC_W-1:0] out_prod [2];
  logic [AUDIO_W:0]        out_sat  [2];
  stereo_frame_t           s3_frame;

  always_comb begin
    mix_sum[0] = '0;                     // unrouted bus stays 0
    mix_sum[1] = '0;
    for (int i = 0; i < NR_CH; i++) begin
      if (s1_pan[i]) begin
        mix_sum[1] = mix_sum[1] + s1_ch[i];
      end else begin
        mix_sum[0] = mix_sum[0] + s1_ch[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_sum[0] <= mix_sum[0];
      s2_sum[1] <= mix_sum[1];
      s2_gain   <= s1_gain;
    end
  end

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      out_prod[k] = s2_sum[k] * $signed({1'b0, s2_gain});
      out_sat[k]  = scale_sat(out_prod[k]);
    end
  end

  assign s3_frame.left  = out_sat[0][AUDIO_W-1:0];
  assign s3_frame.right = out_sat[1][AUDIO_W-1:0];

  // valids and sticky clip flags, clear wins over a new clip
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      chan_clip <= '0;
      out_clip  <= 1'b0;
    end else begin
      s1_valid <= fifo_valid;
      s2_valid <= s1_valid;
      if (clear_stats) begin
        chan_clip <= '0;
        out_clip  <= 1'b0;
      end else begin
        for (int i = 0; i < NR_CH; i++) begin
          if (fifo_valid && ch_sat[i][AUDIO_W]) begin
            chan_clip[i] <= 1'b1;
          end
        end
        if (s2_valid && (out_sat[0][AUDIO_W] || out_sat[1][AUDIO_W])) begin
          out_clip <= 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // output queue and dac serialiser
  // ------------------------------------------------------------
  stereo_frame_t        q_mem [ENG_SLOTS];
  logic [ENG_PTR_W-1:0] q_wr;
  logic [ENG_PTR_W-1:0] q_rd;
  logic [CRED_W-1:0]    q_cnt;
  logic [CRED_W-1:0]    busy_cnt;  // frames taken but not yet credited back
  ser_state_t           ser_state;
  sample_t              r_hold;    // right sample waiting its turn
  stereo_frame_t        head;
  logic                 take;      // serialiser loads a frame
  logic                 push;
  logic                 pop;
  logic                 right_done;

  assign take       = (ser_state == S_IDLE) && ((q_cnt != '0) || s2_valid);
  assign pop        = take && (q_cnt != '0);
  assign push       = s2_valid && !(take && (q_cnt == '0)); // bypass when queue empty
  assign head       = (q_cnt != '0) ? q_mem[q_rd] : s3_frame;
  assign right_done = (ser_state == S_RIGHT) && dac_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_wr       <= '0;
      q_rd       <= '0;
      q_cnt      <= '0;
      busy_cnt   <= '0;
      ser_state  <= S_IDLE;
      dac_valid  <= 1'b0;
      dac_last   <= 1'b0;
      eng_credit <= 1'b0;
    end else begin
      if (push) begin
        q_wr <= q_wr + 1'b1;
      end
      if (pop) begin
        q_rd <= q_rd + 1'b1;
      end
      q_cnt      <= q_cnt + CRED_W'(push) - CRED_W'(pop);
      busy_cnt   <= busy_cnt + CRED_W'(fifo_valid) - CRED_W'(eng_credit);
      eng_credit <= right_done;          // slot free once right sample is out
      case (ser_state)
        S_IDLE: begin
          if (take) begin
            ser_state <= S_LEFT;
            dac_valid <= 1'b1;
            dac_last  <= 1'b0;
          end
        end
        S_LEFT: begin
          if (dac_ready) begin
            ser_state <= S_RIGHT;
            dac_last  <= 1'b1;
          end
        end
        S_RIGHT: begin
          if (dac_ready) begin
            ser_state <= S_IDLE;
            dac_valid <= 1'b0;
            dac_last  <= 1'b0;
          end
        end
        default: ser_state <= S_IDLE;
      endcase
    end
  end

  // queue slots and dac payload
  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[q_wr] <= s3_frame;
    end
    if (take) begin
      dac_data <= head.left;
      r_hold   <= head.right;
    end else if ((ser_state == S_LEFT) && dac_ready) begin
      dac_data <= r_hold;
    end
  end

  // the buffer's credits keep a third frame out while both slots are committed
  a_no_frame_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_valid |-> (busy_cnt < CRED_W'(ENG_SLOTS)));

endmodule

/* verilog/mixer_top.sv */
`timescale 1ns/1ps
// stereo mixer: adc stream -> frame assembler -> frame buffer -> mix engine -> dac stream
// both streams use valid/ready, internal links run on credits
// single clock domain
module mixer_top
  import mix_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,
  // adc stream
  input  sample_t          adc_data,
  input  logic             adc_valid,
  input  logic             adc_last,
  output logic             adc_ready,
  // dac stream
  output sample_t          dac_data,
  output logic             dac_valid,
  output logic             dac_last,
  input  logic             dac_ready,
  // configuration and status
  input  gain_t            chan_gain_0,
  input  gain_t            chan_gain_1,
  input  gain_t            out_gain,
  input  logic [NR_CH-1:0] chan_pan,
  input  logic             clear_stats,
  output sample_t          min_amp,
  output sample_t          max_amp,
  output logic [NR_CH-1:0] chan_clip,
  output logic             out_clip
);

  // ------------------------------------------------------------
  // internal credit links
  // ------------------------------------------------------------
  logic          asm_valid;
  stereo_frame_t asm_frame;
  logic          asm_credit;
  logic          fifo_valid;
  stereo_frame_t fifo_frame;
  logic          eng_credit;

  frame_assembler u_asm (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .adc_data    ( adc_data    ),
    .adc_valid   ( adc_valid   ),
    .adc_last    ( adc_last    ),
    .adc_ready   ( adc_ready   ),
    .clear_stats ( clear_stats ),
    .min_amp     ( min_amp     ),
    .max_amp     ( max_amp     ),
    .asm_valid   ( asm_valid   ),
    .asm_frame   ( asm_frame   ),
    .asm_credit  ( asm_credit  )
  );

  frame_fifo u_fifo (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .asm_valid  ( asm_valid  ),
    .asm_frame  ( asm_frame  ),
    .asm_credit ( asm_credit ),
    .fifo_valid ( fifo_valid ),
    .fifo_frame ( fifo_frame ),
    .eng_credit ( eng_credit )
  );

  mix_engine u_eng (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .fifo_valid  ( fifo_valid  ),
    .fifo_frame  ( fifo_frame  ),
    .eng_credit  ( eng_credit  ),
    .chan_gain_0 ( chan_gain_0 ),
    .chan_gain_1 ( chan_gain_1 ),
    .out_gain    ( out_gain    ),
    .chan_pan    ( chan_pan    ),
    .clear_stats ( clear_stats ),
    .chan_clip   ( chan_clip   ),
    .out_clip    ( out_clip    ),
    .dac_data    ( dac_data    ),
    .dac_valid   ( dac_valid   ),
    .dac_last    ( dac_last    ),
    .dac_ready   ( dac_ready   )
  );

endmodule

/* dv/mixer_tb.sv */
`timescale 1ns/1ps
// drives the stereo mixer from dv/mixer_patterns.txt, run from the project root
// records sharing a name form one test, gains, pan and stall mode come from its first record
// clip flags and min/max are checked after the last record of a test, then cleared
module mixer_tb
  import mix_pkg::*;
();

  localparam int MAX_REC    = 64;   // pattern records held
  localparam int TIMEOUT    = 1000; // cycles allowed per wait
  localparam int LONG_STALL = 40;   // dac held off long enough to drain adc credits

  logic             clk;
  logic             rst_n;
  sample_t          adc_data;
  logic             adc_valid;
  logic             adc_last;
  logic             adc_ready;
  sample_t          dac_data;
  logic             dac_valid;
  logic             dac_last;
  logic             dac_ready;
  gain_t            chan_gain_0;
  gain_t            chan_gain_1;
  gain_t            out_gain;
  logic [NR_CH-1:0] chan_pan;
  logic             clear_stats;
  sample_t          min_amp;
  sample_t          max_amp;
  logic [NR_CH-1:0] chan_clip;
  logic             out_clip;

  // ------------------------------------------------------------
  // pattern records, one slot per file line
  // ------------------------------------------------------------
  string            p_name  [MAX_REC];
  gain_t            p_g0    [MAX_REC];
  gain_t            p_g1    [MAX_REC];
  gain_t            p_og    [MAX_REC];
  logic [NR_CH-1:0] p_pan   [MAX_REC];
  logic             p_stall [MAX_REC]; // 1 = long dac stall up front
  sample_t          p_in_l  [MAX_REC];
  sample_t          p_in_r  [MAX_REC];
  sample_t          p_exp_l [MAX_REC];
  sample_t          p_exp_r [MAX_REC];
  logic [NR_CH:0]   p_clip  [MAX_REC]; // {chan_clip, out_clip}
  sample_t          p_min   [MAX_REC];
  sample_t          p_max   [MAX_REC];
  int               n_rec;

  integer  seed;
  int      test_errs;
  int      total_errs;
  int      tests_run;
  int      tests_failed;
  logic    aborted;       // a wait timed out, skip the rest
  logic    saw_stall;     // adc_ready seen low while sending
  sample_t got_data [$];  // dac samples in arrival order
  logic    got_last [$];

  mixer_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  task automatic check_value(input string test, input string what,
                             input sample_t exp, input sample_t act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s expected %h actual %h", test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_timeout(input string test, input string what);
    $display("ERROR %s: timed out waiting for %s", test, what);
    test_errs++;
    aborted = 1'b1;
  endtask

  task automatic read_patterns();
    int    fd;
    int    rc;
    string line;
    fd    = $fopen("dv/mixer_patterns.txt", "r");
    n_rec = 0;
    if (fd == 0) begin
      $display("ERROR cannot open dv/mixer_patterns.txt");
      total_errs++;
      return;
    end
    while (!$feof(fd) && n_rec < MAX_REC) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 4 && line[0] != "#") begin // skip blanks and comments
        rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                     p_name[n_rec], p_g0[n_rec], p_g1[n_rec], p_og[n_rec],
                     p_pan[n_rec], p_stall[n_rec], p_in_l[n_rec], p_in_r[n_rec],
                     p_exp_l[n_rec], p_exp_r[n_rec], p_clip[n_rec],
                     p_min[n_rec], p_max[n_rec]);
        if (rc == 13) begin
          n_rec++;
        end else begin
          $display("ERROR malformed pattern line: %s", line);
          total_errs++;
        end
      end
    end
    $fclose(fd);
    if (n_rec == 0) begin
      $display("ERROR no pattern records found");
      total_errs++;
    end
  endtask

  // ------------------------------------------------------------
  // adc driver and dac collector, both act 1 ns after the edge
  // ------------------------------------------------------------
  task automatic send_sample(input string test, input sample_t d, input logic last);
    int cycles;
    cycles    = 0;
    adc_data  = d;
    adc_last  = last;
    adc_valid = 1'b1;
    while (!adc_ready && cycles < TIMEOUT) begin
      saw_stall = 1'b1;
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!adc_ready) begin
      report_timeout(test, "adc_ready");
    end else begin
      @(posedge clk); // transfer on this edge
      #1;
    end
  endtask

  task automatic send_frames(input string test, input int first, input int n);
    for (int k = first; k < first + n; k++) begin
      if (!aborted) begin
        send_sample(test, p_in_l[k], 1'b0); // left
        send_sample(test, p_in_r[k], 1'b1); // right
      end
    end
    adc_valid = 1'b0;
  endtask

  task automatic collect(input string test, input int n, input logic stall);
    int cycles;
    cycles = 0;
    got_data.delete();
    got_last.delete();
    while (got_data.size() < 2 * n && cycles < TIMEOUT) begin
      if (stall && cycles < LONG_STALL) begin
        dac_ready = 1'b0;
      end else begin
        dac_ready = (($random(seed) & 3) != 0); // ready about 3 cycles in 4
      end
      if (dac_valid && dac_ready) begin
        got_data.push_back(dac_data);
        got_last.push_back(dac_last);
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    dac_ready = 1'b1;
    if (got_data.size() < 2 * n) begin
      report_timeout(test, "dac samples");
    end
  endtask

  task automatic finish_test(input string test, input int n);
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0) begin
      tests_failed++;
      $display("test %-12s failed, %0d errors", test, test_errs);
    end else begin
      $display("test %-12s passed, %0d frames", test, n);
    end
  endtask

  task automatic run_test(input int first, input int n);
    string name;
    int    last;
    name        = p_name[first];
    last        = first + n - 1;
    test_errs   = 0;
    saw_stall   = 1'b0;
    chan_gain_0 = p_g0[first]; // design idle, safe to change
    chan_gain_1 = p_g1[first];
    out_gain    = p_og[first];
    chan_pan    = p_pan[first];
    @(posedge clk);
    #1;
    fork
      send_frames(name, first, n);
      collect(name, n, p_stall[first]);
    join
    for (int k = 0; k < n; k++) begin
      if (2 * k + 1 < got_data.size()) begin
        check_value(name, "left", p_exp_l[first + k], got_data[2 * k]);
        check_value(name, "right", p_exp_r[first + k], got_data[2 * k + 1]);
        check_value(name, "left dac_last", '0, got_last[2 * k]);
        check_value(name, "right dac_last", 1, got_last[2 * k + 1]);
      end
    end
    if (p_stall[first] && !saw_stall) begin
      $display("ERROR %s: adc_ready never went low during the dac stall", name);
      test_errs++;
    end
    check_value(name, "clip", p_clip[last], {chan_clip, out_clip});
    check_value(name, "min_amp", p_min[last], min_amp);
    check_value(name, "max_amp", p_max[last], max_amp);
    clear_stats = 1'b1; // one-cycle clear
    @(posedge clk);
    #1;
    clear_stats = 1'b0;
    check_value(name, "clip after clear", '0, {chan_clip, out_clip});
    check_value(name, "min_amp after clear", '0, min_amp);
    check_value(name, "max_amp after clear", '0, max_amp);
    finish_test(name, n);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    int first;
    int n;
    seed         = 32'h5f948be7;
    rst_n        = 1'b0;
    adc_data     = '0;
    adc_valid    = 1'b0;
    adc_last     = 1'b0;
    dac_ready    = 1'b1;
    chan_gain_0  = gain_t'(256);
    chan_gain_1  = gain_t'(256);
    out_gain     = gain_t'(256);
    chan_pan     = 2'b10;
    clear_stats  = 1'b0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    read_patterns();
    repeat (2) @(posedge clk);
    #1;
    rst_n     = 1'b1;
    test_errs = 0;
    check_value("reset", "dac_valid", '0, dac_valid);
    check_value("reset", "adc_ready", 1, adc_ready);
    check_value("reset", "clip", '0, {chan_clip, out_clip});
    check_value("reset", "min_amp", '0, min_amp);
    check_value("reset", "max_amp", '0, max_amp);
    finish_test("reset", 0);
    first = 0;
    while (first < n_rec && !aborted) begin
      n = 1;
      while (first + n < n_rec && p_name[first + n] == p_name[first]) begin
        n++; // group consecutive records of one test
      end
      run_test(first, n);
      first += n;
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* dv/mixer_patterns.txt */
# name g0 g1 out_gain pan stall adc_l adc_r exp_l exp_r clip min max, all hex
# clip is {chan_clip[1], chan_clip[0], out_clip}, clip/min/max checked after a test's last line
passthru     100 100 100 2 0 000123 fffe00 000123 fffe00 0 800000 7fffff
passthru     100 100 100 2 0 7fffff 800000 7fffff 800000 0 800000 7fffff
passthru     100 100 100 2 0 abcdef 012345 abcdef 012345 0 800000 7fffff
passthru     100 100 100 2 0 000000 000001 000000 000001 0 800000 7fffff
gainpan      080 200 100 0 0 000101 000010 0000a0 000000 0 ffff01 001000
gainpan      080 200 100 0 0 ffffff 000003 000005 000000 0 ffff01 001000
gainpan      080 200 100 0 0 ffff01 fffff0 ffff60 000000 0 ffff01 001000
gainpan      080 200 100 0 0 001000 000800 001800 000000 0 ffff01 001000
saturate     fff 400 200 2 0 400000 c00000 7fffff 800000 7 c00000 400000
saturate     fff 400 200 2 0 000010 fffffc 0001fe ffffe0 7 c00000 400000
stats        100 100 100 2 0 000005 000003 000005 000003 0 fffff9 000011
stats        100 100 100 2 0 fffff9 000002 fffff9 000002 0 fffff9 000011
stats        100 100 100 2 0 000011 fffffe 000011 fffffe 0 fffff9 000011
stats_pos    100 100 100 2 0 000010 000020 000010 000020 0 000000 000030
stats_pos    100 100 100 2 0 000008 000030 000008 000030 0 000000 000030
backpressure 100 100 100 2 1 000101 ffff01 000101 ffff01 0 ffff01 00010c
backpressure 100 100 100 2 1 000102 ffff02 000102 ffff02 0 ffff01 00010c
backpressure 100 100 100 2 1 000103 ffff03 000103 ffff03 0 ffff01 00010c
backpressure 100 100 100 2 1 000104 ffff04 000104 ffff04 0 ffff01 00010c
backpressure 100 100 100 2 1 000105 ffff05 000105 ffff05 0 ffff01 00010c
backpressure 100 100 100 2 1 000106 ffff06 000106 ffff06 0 ffff01 00010c
backpressure 100 100 100 2 1 000107 ffff07 000107 ffff07 0 ffff01 00010c
backpressure 100 100 100 2 1 000108 ffff08 000108 ffff08 0 ffff01 00010c
backpressure 100 100 100 2 1 000109 ffff09 000109 ffff09 0 ffff01 00010c
backpressure 100 100 100 2 1 00010a ffff0a 00010a ffff0a 0 ffff01 00010c
backpressure 100 100 100 2 1 00010b ffff0b 00010b ffff0b 0 ffff01 00010c
backpressure 100 100 100 2 1 00010c ffff0c 00010c ffff0c 0 ffff01 00010c

/* project.f */
verilog/mix_pkg.sv
verilog/frame_assembler.sv
verilog/frame_fifo.sv
verilog/mix_engine.sv
verilog/mixer_top.sv
dv/mixer_tb.sv
